// File: common/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	// Datapath widths
	localparam int unsigned word_width     = 32;
	localparam int unsigned reg_addr_width = 5;

	// First fetch after reset
	localparam logic [word_width-1:0] reset_pc = '0;

	typedef enum logic [3:0] {
		OP_NOP,
		OP_ADDU,
		OP_SUBU,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_SLT,
		OP_ADDIU,
		OP_LUI,
		OP_LW,
		OP_SW,
		OP_BEQ,
		OP_BNE,
		OP_J
	} oper_t;

	// Primary opcode field, inst[31:26]
	localparam logic [5:0] opc_special = 6'b000000;
	localparam logic [5:0] opc_j       = 6'b000010;
	localparam logic [5:0] opc_beq     = 6'b000100;
	localparam logic [5:0] opc_bne     = 6'b000101;
	localparam logic [5:0] opc_addiu   = 6'b001001;
	localparam logic [5:0] opc_lui     = 6'b001111;
	localparam logic [5:0] opc_lw      = 6'b100011;
	localparam logic [5:0] opc_sw      = 6'b101011;

	// Function field for SPECIAL, inst[5:0]
	localparam logic [5:0] fn_addu = 6'b100001;
	localparam logic [5:0] fn_subu = 6'b100011;
	localparam logic [5:0] fn_and  = 6'b100100;
	localparam logic [5:0] fn_or   = 6'b100101;
	localparam logic [5:0] fn_xor  = 6'b100110;
	localparam logic [5:0] fn_slt  = 6'b101010;

endpackage

`default_nettype wire

// File: design/regs.sv
`timescale 1ns/100ps
`default_nettype none

module regs(
	input  logic                                clk_i,
	input  logic                                arst_n_i,
	input  logic                                we_i,
	input  logic [cpu_pkg::reg_addr_width-1:0] waddr_i,
	input  logic [cpu_pkg::word_width-1:0]     wdata_i,
	input  logic [cpu_pkg::reg_addr_width-1:0] raddr1_i,
	input  logic [cpu_pkg::reg_addr_width-1:0] raddr2_i,
	output logic [cpu_pkg::word_width-1:0]     rdata1_o,
	output logic [cpu_pkg::word_width-1:0]     rdata2_o
);

	// r0 is cleared by reset and never written
	logic [cpu_pkg::word_width-1:0] regs_q [0:31];

	function automatic logic [cpu_pkg::word_width-1:0] read_port(
		input logic [cpu_pkg::reg_addr_width-1:0] addr
	);
		// Write-through so WB lands in ID the same cycle
		if (we_i && waddr_i != '0 && waddr_i == addr)
			return wdata_i;
		return regs_q[addr];
	endfunction

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < 32; i++)
				regs_q[i] <= '0;
		end else if (we_i && waddr_i != '0) begin
			regs_q[waddr_i] <= wdata_i;
		end
	end

	always_comb begin
		rdata1_o = read_port(raddr1_i);
		rdata2_o = read_port(raddr2_i);
	end

	// A write aimed at r0 must leave it reading zero afterwards
	r0_stays_zero: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		(we_i && waddr_i == '0) ##1 (raddr1_i == '0) |-> rdata1_o == '0)
		else $error("r0 read back nonzero after a write to it");

endmodule

`default_nettype wire

// File: design/cpu_id.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_id(
	input  logic [cpu_pkg::word_width-1:0]     pc_i,
	input  logic [cpu_pkg::word_width-1:0]     inst_i,
	input  logic [cpu_pkg::word_width-1:0]     reg1_i,
	input  logic [cpu_pkg::word_width-1:0]     reg2_i,
	input  logic                                ex_we_i,
	input  logic [cpu_pkg::reg_addr_width-1:0] ex_waddr_i,
	input  logic [cpu_pkg::word_width-1:0]     ex_wdata_i,
	input  logic                                ex_is_load_i,
	input  logic                                mem_we_i,
	input  logic [cpu_pkg::reg_addr_width-1:0] mem_waddr_i,
	input  logic [cpu_pkg::word_width-1:0]     mem_wdata_i,
	output logic [cpu_pkg::reg_addr_width-1:0] reg_raddr1_o,
	output logic [cpu_pkg::reg_addr_width-1:0] reg_raddr2_o,
	output cpu_pkg::oper_t                      op_o,
	output logic [cpu_pkg::word_width-1:0]     reg1_o,
	output logic [cpu_pkg::word_width-1:0]     reg2_o,
	output logic [cpu_pkg::word_width-1:0]     imm_o,
	output logic                                reg_we_o,
	output logic [cpu_pkg::reg_addr_width-1:0] reg_waddr_o,
	output logic                                stall_o,
	output logic                                jump_o,
	output logic [cpu_pkg::word_width-1:0]     jump_to_o
);

	logic [5:0]                          opcode;
	logic [5:0]                          funct;
	logic [cpu_pkg::reg_addr_width-1:0] rs;
	logic [cpu_pkg::reg_addr_width-1:0] rt;
	logic [cpu_pkg::reg_addr_width-1:0] rd;
	logic [cpu_pkg::word_width-1:0]     sext_imm;
	logic [cpu_pkg::word_width-1:0]     pc_plus4;
	logic                                uses_rs;
	logic                                uses_rt;

	assign opcode   = inst_i[31:26];
	assign rs       = inst_i[25:21];
	assign rt       = inst_i[20:16];
	assign rd       = inst_i[15:11];
	assign funct    = inst_i[5:0];
	assign sext_imm = {{16{inst_i[15]}}, inst_i[15:0]};
	assign pc_plus4 = pc_i + 32'd4;

	assign reg_raddr1_o = rs;
	assign reg_raddr2_o = rt;

	// Youngest producer wins: EX, then MEM, then register file
	function automatic logic [cpu_pkg::word_width-1:0] forward(
		input logic [cpu_pkg::reg_addr_width-1:0] addr,
		input logic [cpu_pkg::word_width-1:0]     rf_data
	);
		if (addr != '0 && ex_we_i && ex_waddr_i == addr)
			return ex_wdata_i;
		if (addr != '0 && mem_we_i && mem_waddr_i == addr)
			return mem_wdata_i;
		return rf_data;
	endfunction

	always_comb begin
		op_o = cpu_pkg::OP_NOP;
		case (opcode)
			cpu_pkg::opc_special: begin
				case (funct)
					cpu_pkg::fn_addu: op_o = cpu_pkg::OP_ADDU;
					cpu_pkg::fn_subu: op_o = cpu_pkg::OP_SUBU;
					cpu_pkg::fn_and:  op_o = cpu_pkg::OP_AND;
					cpu_pkg::fn_or:   op_o = cpu_pkg::OP_OR;
					cpu_pkg::fn_xor:  op_o = cpu_pkg::OP_XOR;
					cpu_pkg::fn_slt:  op_o = cpu_pkg::OP_SLT;
					default:          op_o = cpu_pkg::OP_NOP;
				endcase
			end
			cpu_pkg::opc_addiu: op_o = cpu_pkg::OP_ADDIU;
			cpu_pkg::opc_lui:   op_o = cpu_pkg::OP_LUI;
			cpu_pkg::opc_lw:    op_o = cpu_pkg::OP_LW;
			cpu_pkg::opc_sw:    op_o = cpu_pkg::OP_SW;
			cpu_pkg::opc_beq:   op_o = cpu_pkg::OP_BEQ;
			cpu_pkg::opc_bne:   op_o = cpu_pkg::OP_BNE;
			cpu_pkg::opc_j:     op_o = cpu_pkg::OP_J;
			default:            op_o = cpu_pkg::OP_NOP;
		endcase
	end

	always_comb begin
		imm_o       = sext_imm;
		reg_we_o    = 1'b0;
		reg_waddr_o = rt;
		uses_rs     = 1'b0;
		uses_rt     = 1'b0;
		case (op_o)
			cpu_pkg::OP_ADDU, cpu_pkg::OP_SUBU, cpu_pkg::OP_AND,
			cpu_pkg::OP_OR, cpu_pkg::OP_XOR, cpu_pkg::OP_SLT: begin
				uses_rs     = 1'b1;
				uses_rt     = 1'b1;
				reg_we_o    = 1'b1;
				reg_waddr_o = rd;
			end
			cpu_pkg::OP_ADDIU, cpu_pkg::OP_LW: begin
				uses_rs  = 1'b1;
				reg_we_o = 1'b1;
			end
			cpu_pkg::OP_LUI: begin
				imm_o    = {16'b0, inst_i[15:0]};
				reg_we_o = 1'b1;
			end
			// Store data rides on rt
			cpu_pkg::OP_SW, cpu_pkg::OP_BEQ, cpu_pkg::OP_BNE: begin
				uses_rs = 1'b1;
				uses_rt = 1'b1;
			end
			default: ;
		endcase
	end

	always_comb begin
		reg1_o = forward(rs, reg1_i);
		reg2_o = forward(rt, reg2_i);
	end

	assign jump_o = (op_o == cpu_pkg::OP_BEQ && reg1_o == reg2_o)
		|| (op_o == cpu_pkg::OP_BNE && reg1_o != reg2_o)
		|| op_o == cpu_pkg::OP_J;

	// Targets relative to the delay slot
	assign jump_to_o = (op_o == cpu_pkg::OP_J)
		? {pc_plus4[31:28], inst_i[25:0], 2'b00}
		: pc_plus4 + {sext_imm[29:0], 2'b00};

	assign stall_o = ex_is_load_i && ex_waddr_i != '0
		&& ((uses_rs && ex_waddr_i == rs) || (uses_rt && ex_waddr_i == rt));

endmodule

`default_nettype wire

// File: design/cpu_ex.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_ex(
	input  cpu_pkg::oper_t                  op_i,
	input  logic [cpu_pkg::word_width-1:0] reg1_i,
	input  logic [cpu_pkg::word_width-1:0] reg2_i,
	input  logic [cpu_pkg::word_width-1:0] imm_i,
	output logic [cpu_pkg::word_width-1:0] result_o
);

	logic [cpu_pkg::word_width-1:0] sum_imm;
	logic                            less;

	// Shared by ADDIU and the load/store address
	assign sum_imm = reg1_i + imm_i;
	assign less    = $signed(reg1_i) < $signed(reg2_i);

	always_comb begin
		case (op_i)
			cpu_pkg::OP_ADDU:  result_o = reg1_i + reg2_i;
			cpu_pkg::OP_SUBU:  result_o = reg1_i - reg2_i;
			cpu_pkg::OP_AND:   result_o = reg1_i & reg2_i;
			cpu_pkg::OP_OR:    result_o = reg1_i | reg2_i;
			cpu_pkg::OP_XOR:   result_o = reg1_i ^ reg2_i;
			cpu_pkg::OP_SLT:   result_o = {31'b0, less};
			cpu_pkg::OP_ADDIU: result_o = sum_imm;
			cpu_pkg::OP_LUI:   result_o = {imm_i[15:0], 16'b0};
			cpu_pkg::OP_LW:    result_o = sum_imm;
			cpu_pkg::OP_SW:    result_o = sum_imm;
			// Branches, jump and NOP
			default:           result_o = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: design/trivial_mips.sv
`timescale 1ns/100ps
`default_nettype none

module trivial_mips(
	input  logic                            clk_i,
	input  logic                            arst_n_i,
	input  logic [cpu_pkg::word_width-1:0] inst_i,
	input  logic [cpu_pkg::word_width-1:0] data_rdata_i,
	output logic [cpu_pkg::word_width-1:0] inst_addr_o,
	output logic [cpu_pkg::word_width-1:0] data_addr_o,
	output logic [cpu_pkg::word_width-1:0] data_wdata_o,
	output logic                            data_we_o,
	output logic                            data_re_o
);

	logic [cpu_pkg::word_width-1:0]     pc_q;
	logic                                id_valid_q, ex_valid_q, mem_valid_q, wb_valid_q;

	// IF/ID
	logic [cpu_pkg::word_width-1:0]     id_pc_q, id_inst_q, id_inst;
	// ID stage
	logic [cpu_pkg::reg_addr_width-1:0] reg_raddr1, reg_raddr2, id_reg_waddr;
	logic [cpu_pkg::word_width-1:0]     reg_rdata1, reg_rdata2;
	logic [cpu_pkg::word_width-1:0]     id_reg1, id_reg2, id_imm, jump_to;
	cpu_pkg::oper_t                      id_op;
	logic                                id_reg_we, stall, jump;
	// ID/EX
	cpu_pkg::oper_t                      ex_op_q;
	logic [cpu_pkg::word_width-1:0]     ex_reg1_q, ex_reg2_q, ex_imm_q, ex_result;
	logic                                ex_we_q, ex_fwd_we, ex_is_load;
	logic [cpu_pkg::reg_addr_width-1:0] ex_waddr_q;
	// EX/MEM
	cpu_pkg::oper_t                      mem_op_q;
	logic [cpu_pkg::word_width-1:0]     mem_result_q, mem_wdata_q, mem_value;
	logic                                mem_we_q, mem_fwd_we;
	logic [cpu_pkg::reg_addr_width-1:0] mem_waddr_q;
	// MEM/WB
	logic                                wb_we_q;
	logic [cpu_pkg::reg_addr_width-1:0] wb_waddr_q;
	logic [cpu_pkg::word_width-1:0]     wb_wdata_q;

	assign inst_addr_o = pc_q;

	// Empty slot decodes as NOP
	assign id_inst = id_valid_q ? id_inst_q : '0;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pc_q        <= cpu_pkg::reset_pc;
			id_valid_q  <= 1'b0;
			ex_valid_q  <= 1'b0;
			mem_valid_q <= 1'b0;
			wb_valid_q  <= 1'b0;
		end else begin
			if (!stall) begin
				pc_q       <= jump ? jump_to : pc_q + 32'd4;
				id_valid_q <= 1'b1;
			end
			// Load-use bubble enters EX here
			ex_valid_q  <= id_valid_q && !stall;
			mem_valid_q <= ex_valid_q;
			wb_valid_q  <= mem_valid_q;
		end
	end

	always_ff @(posedge clk_i) begin
		if (!stall) begin
			id_pc_q   <= pc_q;
			id_inst_q <= inst_i;
		end
		ex_op_q      <= id_op;
		ex_reg1_q    <= id_reg1;
		ex_reg2_q    <= id_reg2;
		ex_imm_q     <= id_imm;
		ex_we_q      <= id_reg_we;
		ex_waddr_q   <= id_reg_waddr;
		mem_op_q     <= ex_op_q;
		mem_result_q <= ex_result;
		mem_wdata_q  <= ex_reg2_q;
		mem_we_q     <= ex_we_q;
		mem_waddr_q  <= ex_waddr_q;
		wb_we_q      <= mem_we_q;
		wb_waddr_q   <= mem_waddr_q;
		wb_wdata_q   <= mem_value;
	end

	regs general_regs_instance(
		.clk_i,
		.arst_n_i,
		.we_i(wb_valid_q && wb_we_q),
		.waddr_i(wb_waddr_q),
		.wdata_i(wb_wdata_q),
		.raddr1_i(reg_raddr1),
		.raddr2_i(reg_raddr2),
		.rdata1_o(reg_rdata1),
		.rdata2_o(reg_rdata2)
	);

	assign ex_fwd_we  = ex_valid_q && ex_we_q;
	assign ex_is_load = ex_valid_q && ex_op_q == cpu_pkg::OP_LW;
	assign mem_fwd_we = mem_valid_q && mem_we_q;

	cpu_id stage_id(
		.pc_i(id_pc_q),
		.inst_i(id_inst),
		.reg1_i(reg_rdata1),
		.reg2_i(reg_rdata2),
		.ex_we_i(ex_fwd_we),
		.ex_waddr_i(ex_waddr_q),
		.ex_wdata_i(ex_result),
		.ex_is_load_i(ex_is_load),
		.mem_we_i(mem_fwd_we),
		.mem_waddr_i(mem_waddr_q),
		.mem_wdata_i(mem_value),
		.reg_raddr1_o(reg_raddr1),
		.reg_raddr2_o(reg_raddr2),
		.op_o(id_op),
		.reg1_o(id_reg1),
		.reg2_o(id_reg2),
		.imm_o(id_imm),
		.reg_we_o(id_reg_we),
		.reg_waddr_o(id_reg_waddr),
		.stall_o(stall),
		.jump_o(jump),
		.jump_to_o(jump_to)
	);

	cpu_ex stage_ex(
		.op_i(ex_op_q),
		.reg1_i(ex_reg1_q),
		.reg2_i(ex_reg2_q),
		.imm_i(ex_imm_q),
		.result_o(ex_result)
	);

	// MEM stage
	assign data_addr_o  = mem_result_q;
	assign data_wdata_o = mem_wdata_q;
	assign data_we_o    = mem_valid_q && mem_op_q == cpu_pkg::OP_SW;
	assign data_re_o    = mem_valid_q && mem_op_q == cpu_pkg::OP_LW;
	assign mem_value    = (mem_op_q == cpu_pkg::OP_LW) ? data_rdata_i : mem_result_q;

	// A single bubble always clears the hazard
	stall_one_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		stall |=> !stall)
		else $error("load-use stall held for two cycles");

endmodule

`default_nettype wire

// File: verification/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

function automatic logic [31:0] r_type(input logic [5:0] fn, input logic [4:0] rd,
	input logic [4:0] rs, input logic [4:0] rt);
	return {cpu_pkg::opc_special, rs, rt, rd, 5'd0, fn};
endfunction

function automatic logic [31:0] i_type(input logic [5:0] opc, input logic [4:0] rt,
	input logic [4:0] rs, input logic [15:0] imm);
	return {opc, rs, rt, imm};
endfunction

// Store to a scratch word, only reached if a branch goes wrong
function automatic logic [31:0] poison_store();
	return i_type(cpu_pkg::opc_sw, 5'd0, 5'd0, 16'h00FC);
endfunction

task automatic emit(input logic [31:0] word);
	rom[program_words] = word;
	program_words++;
endtask

// SW of rt to addr(r0), recorded as the next expected store
task automatic expect_store(input logic [4:0] rt, input logic [15:0] addr,
	input logic [31:0] value);
	emit(i_type(cpu_pkg::opc_sw, rt, 5'd0, addr));
	exp_addr[exp_count] = {16'b0, addr};
	exp_data[exp_count] = value;
	exp_count++;
endtask

// Expected data is the random word at src plus k
task automatic loaded_store(input logic [4:0] rt, input logic [15:0] addr,
	input logic [15:0] src, input logic [31:0] k);
	expect_store(rt, addr, dmem[src[7:2]] + k);
endtask

task automatic load_program();
	program_words = 0;
	exp_count     = 0;
	// ALU and immediate operations
	emit(i_type(cpu_pkg::opc_addiu, 5'd1, 5'd0, 16'h1234));
	emit(i_type(cpu_pkg::opc_addiu, 5'd2, 5'd0, 16'hFFFD));
	emit(i_type(cpu_pkg::opc_lui, 5'd3, 5'd0, 16'hA5A5));
	emit(r_type(cpu_pkg::fn_addu, 5'd4, 5'd1, 5'd2));
	emit(r_type(cpu_pkg::fn_subu, 5'd5, 5'd1, 5'd2));
	emit(r_type(cpu_pkg::fn_or, 5'd6, 5'd3, 5'd1));
	emit(r_type(cpu_pkg::fn_and, 5'd7, 5'd6, 5'd2));
	emit(r_type(cpu_pkg::fn_xor, 5'd8, 5'd6, 5'd2));
	emit(r_type(cpu_pkg::fn_slt, 5'd9, 5'd2, 5'd1));
	emit(r_type(cpu_pkg::fn_slt, 5'd10, 5'd1, 5'd2));
	expect_store(5'd4, 16'h0080, 32'h0000_1234 + 32'hFFFF_FFFD);
	expect_store(5'd5, 16'h0084, 32'h0000_1234 - 32'hFFFF_FFFD);
	expect_store(5'd6, 16'h0088, 32'hA5A5_0000 | 32'h0000_1234);
	expect_store(5'd7, 16'h008C, 32'hA5A5_1234 & 32'hFFFF_FFFD);
	expect_store(5'd8, 16'h0090, 32'hA5A5_1234 ^ 32'hFFFF_FFFD);
	// Signed compare, -3 < 0x1234
	expect_store(5'd9, 16'h0094, 32'd1);
	expect_store(5'd10, 16'h0098, 32'd0);
	// Dependent chain, every result read by the next two instructions
	emit(i_type(cpu_pkg::opc_addiu, 5'd11, 5'd0, 16'd5));
	emit(i_type(cpu_pkg::opc_addiu, 5'd12, 5'd11, 16'd7));
	emit(r_type(cpu_pkg::fn_addu, 5'd13, 5'd12, 5'd11));
	emit(r_type(cpu_pkg::fn_addu, 5'd14, 5'd13, 5'd12));
	expect_store(5'd14, 16'h009C, (32'd5 + 32'd7 + 32'd5) + (32'd5 + 32'd7));
	// Load followed at once by a use
	emit(i_type(cpu_pkg::opc_lw, 5'd16, 5'd0, 16'h0010));
	emit(i_type(cpu_pkg::opc_addiu, 5'd17, 5'd16, 16'd3));
	loaded_store(5'd17, 16'h00A0, 16'h0010, 32'd3);
	emit(i_type(cpu_pkg::opc_lw, 5'd18, 5'd0, 16'h0014));
	loaded_store(5'd18, 16'h00A4, 16'h0014, 32'd0);
	// Taken BEQ, its delay slot runs
	emit(i_type(cpu_pkg::opc_beq, 5'd1, 5'd1, 16'd3));
	expect_store(5'd9, 16'h00A8, 32'd1);
	emit(poison_store());
	emit(poison_store());
	// Taken BNE
	emit(i_type(cpu_pkg::opc_bne, 5'd2, 5'd1, 16'd2));
	emit(i_type(cpu_pkg::opc_addiu, 5'd19, 5'd0, 16'h0077));
	emit(poison_store());
	// Not taken, both fall through
	emit(i_type(cpu_pkg::opc_beq, 5'd2, 5'd1, 16'd5));
	expect_store(5'd19, 16'h00AC, 32'h0000_0077);
	emit(i_type(cpu_pkg::opc_bne, 5'd1, 5'd1, 16'd4));
	emit(i_type(cpu_pkg::opc_addiu, 5'd0, 5'd0, 16'h0055));
	expect_store(5'd0, 16'h00B0, 32'd0);
	// J lands past its delay slot and one skipped store
	emit({cpu_pkg::opc_j, 26'(program_words + 3)});
	expect_store(5'd1, 16'h00B4, 32'h0000_1234);
	emit(poison_store());
	expect_store(5'd2, 16'h00B8, 32'hFFFF_FFFD);
	program_loaded = 1'b1;
endtask

`endif

// File: verification/tb_trivial_mips.sv
`timescale 1ns/100ps
`default_nettype none

module tb_trivial_mips;

	localparam int clk_period   = 20;
	localparam int reset_cycles = 2;
	localparam int rom_words    = 64;
	localparam int dmem_words   = 64;
	localparam int max_stores   = 32;

	logic        clk;
	logic        arst_n;
	logic [31:0] inst;
	logic [31:0] data_rdata;
	logic [31:0] inst_addr;
	logic [31:0] data_addr;
	logic [31:0] data_wdata;
	logic        data_we;
	logic        data_re;

	logic [31:0] rom [0:rom_words-1];
	logic [31:0] dmem [0:dmem_words-1];
	logic [31:0] exp_addr [0:max_stores-1];
	logic [31:0] exp_data [0:max_stores-1];
	int          exp_count;
	int          store_idx;
	int          program_words;
	bit          program_loaded;
	integer      seed;

	`include "tb_program.svh"

	trivial_mips DUT(
		.clk_i(clk),
		.arst_n_i(arst_n),
		.inst_i(inst),
		.data_rdata_i(data_rdata),
		.inst_addr_o(inst_addr),
		.data_addr_o(data_addr),
		.data_wdata_o(data_wdata),
		.data_we_o(data_we),
		.data_re_o(data_re)
	);

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1, "run stopped");
	endtask

	// NOP outside the program
	function automatic logic [31:0] fetch_word(input logic [31:0] addr);
		if (addr < rom_words * 4)
			return rom[addr[7:2]];
		return '0;
	endfunction

	always #(clk_period / 2) clk = ~clk;

	// Both memories answer within the cycle
	always @(posedge clk) begin
		#1;
		inst       <= fetch_word(inst_addr);
		// Read data only appears under the read strobe
		data_rdata <= data_re ? dmem[data_addr[7:2]] : '0;
	end

	always @(posedge clk) begin
		if (data_we)
			dmem[data_addr[7:2]] <= data_wdata;
		if (arst_n && data_we)
			store_idx <= store_idx + 1;
	end

	strobes_low_in_reset: assert property (@(posedge clk) !arst_n |-> !data_we && !data_re)
		else stop_with_failure($sformatf("mismatch at %0t: data strobe high during reset",
			$time));

	first_fetch: assert property (@(posedge clk)
		$rose(arst_n) |-> inst_addr == cpu_pkg::reset_pc && !data_we && !data_re)
		else stop_with_failure($sformatf("mismatch at %0t: first fetch at %h, expected %h",
			$time, $sampled(inst_addr), cpu_pkg::reset_pc));

	strobes_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
		!(data_we && data_re))
		else stop_with_failure("data_we_o and data_re_o were high together");

	no_extra_store: assert property (@(posedge clk) disable iff (!arst_n)
		data_we |-> store_idx < exp_count)
		else stop_with_failure("a store appeared after the last expected one");

	// Stores are checked strictly in program order
	store_matches: assert property (@(posedge clk) disable iff (!arst_n)
		data_we && store_idx < exp_count |->
			data_addr == exp_addr[store_idx] && data_wdata == exp_data[store_idx])
		else stop_with_failure($sformatf(
			"mismatch at %0t: store %0d wrote %h to %h, expected %h to %h",
			$time, $sampled(store_idx), $sampled(data_wdata), $sampled(data_addr),
			exp_data[$sampled(store_idx)], exp_addr[$sampled(store_idx)]));

	initial begin
		wait (program_loaded);
		repeat (reset_cycles + program_words * 4) @(posedge clk);
		stop_with_failure("timeout: the program did not reach its final store in time");
	end

	initial begin
		clk        = 1'b0;
		arst_n     = 1'b1;
		inst       = '0;
		data_rdata = '0;
		store_idx  = 0;
		seed       = 32'h9601_9942;
		for (int i = 0; i < dmem_words; i++)
			dmem[i] = $random(seed);
		for (int i = 0; i < rom_words; i++)
			rom[i] = '0;
		// Expected loaded words come from the filled memory
		load_program();
		#1 arst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		#1 arst_n = 1'b1;
		wait (store_idx == exp_count);
		// A few idle cycles to catch a stray store
		repeat (4) @(posedge clk);
		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+verification
common/cpu_pkg.sv
design/regs.sv
design/cpu_id.sv
design/cpu_ex.sv
design/trivial_mips.sv
verification/tb_trivial_mips.sv

// File: run.sh
#!/bin/sh
# Build and run the trivial_mips testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log
verilator --binary --assert -Wno-fatal --top-module tb_trivial_mips \
	-f filelist.f -o sim_trivial_mips > build.log 2>&1 \
	&& ./obj_dir/sim_trivial_mips > sim.log 2>&1 \
	|| { cat build.log; echo "build or simulation returned an error"; }
cat sim.log 2>/dev/null
grep -q "Everything OK" sim.log 2>/dev/null && echo "PASS" && exit 0 \
	|| { echo "FAIL"; exit 1; }
